// File: modrm_pkg.sv
// mod r/m decode package
// field types, register and segment encodings, width and fsm enums
package modrm_pkg;

    // raw fields of the mod r/m byte
    typedef logic [1:0] mod_t;
    typedef logic [2:0] rm_t;

    // general register index in 386 encoding
    typedef logic [2:0] gpr_idx_t;

    // segment register index in sreg3 encoding
    typedef logic [2:0] sreg_idx_t;

    // displacement length in bytes (0, 1, 2 or 4)
    typedef logic [2:0] disp_len_t;

    // operand width of a register-direct operand
    typedef enum logic [1:0] {
        W_NONE = 2'd0,
        W_8    = 2'd1,
        W_16   = 2'd2,
        W_32   = 2'd3
    } op_width_t;

    // handshake capture fsm
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } capture_state_t;

    // segment registers used by the default segment rule
    localparam sreg_idx_t SREG_SS = 3'd2;
    localparam sreg_idx_t SREG_DS = 3'd3;

    // base/index registers of the 16-bit table
    localparam gpr_idx_t GPR_BX = 3'd3;
    localparam gpr_idx_t GPR_BP = 3'd5;
    localparam gpr_idx_t GPR_SI = 3'd6;
    localparam gpr_idx_t GPR_DI = 3'd7;
    // 32-bit name that shares the BP code
    localparam gpr_idx_t GPR_EBP = GPR_BP;

    // mod value for register-direct
    localparam mod_t MOD_REG = 2'd3;

    // special r/m codes
    localparam rm_t RM_SIB      = 3'd4;
    localparam rm_t RM32_DIRECT = 3'd5;
    localparam rm_t RM16_DIRECT = 3'd6;

    // displacement lengths
    localparam disp_len_t DISP_0  = 3'd0;
    localparam disp_len_t DISP_8  = 3'd1;
    localparam disp_len_t DISP_16 = 3'd2;
    localparam disp_len_t DISP_32 = 3'd4;

endpackage

// File: modrm_ea16_decode.sv
// 16-bit effective address decode
// maps mod and r/m to segment, base, index and displacement length
`timescale 1ns/100ps

module modrm_ea16_decode (
    input  modrm_pkg::mod_t      i_mod,
    input  modrm_pkg::rm_t       i_rm,
    output modrm_pkg::sreg_idx_t o_seg,
    output logic                 o_base_present,
    output modrm_pkg::gpr_idx_t  o_base,
    output logic                 o_index_present,
    output modrm_pkg::gpr_idx_t  o_index,
    output modrm_pkg::disp_len_t o_disp_len
);

    // mod 0 with r/m 6 is a bare disp16 without bp
    logic direct16;

    assign direct16 = (i_mod == 2'b00) && (i_rm == modrm_pkg::RM16_DIRECT);

    // base/index table
    // mod 3 outcome does not matter here
    always_comb begin
        o_base_present  = 1'b0;
        o_base          = '0;
        o_index_present = 1'b0;
        o_index         = '0;
        case (i_rm)
            3'd0, 3'd1: begin
                // bx+si / bx+di
                o_base_present  = 1'b1;
                o_base          = modrm_pkg::GPR_BX;
                o_index_present = 1'b1;
                o_index         = i_rm[0] ? modrm_pkg::GPR_DI : modrm_pkg::GPR_SI;
            end
            3'd2, 3'd3: begin
                // bp+si / bp+di
                o_base_present  = 1'b1;
                o_base          = modrm_pkg::GPR_BP;
                o_index_present = 1'b1;
                o_index         = i_rm[0] ? modrm_pkg::GPR_DI : modrm_pkg::GPR_SI;
            end
            3'd4, 3'd5: begin
                // si or di alone
                o_index_present = 1'b1;
                o_index         = i_rm[0] ? modrm_pkg::GPR_DI : modrm_pkg::GPR_SI;
            end
            3'd6: begin
                o_base_present = ~direct16;
                o_base         = direct16 ? '0 : modrm_pkg::GPR_BP;
            end
            default: begin
                // r/m 7 is bx alone
                o_base_present = 1'b1;
                o_base         = modrm_pkg::GPR_BX;
            end
        endcase
    end

    // bp as base implies the stack segment
    assign o_seg = (o_base_present && (o_base == modrm_pkg::GPR_BP)) ?
                   modrm_pkg::SREG_SS : modrm_pkg::SREG_DS;

    // displacement follows mod plus the direct form
    always_comb begin
        case (i_mod)
            2'b00:   o_disp_len = direct16 ? modrm_pkg::DISP_16 : modrm_pkg::DISP_0;
            2'b01:   o_disp_len = modrm_pkg::DISP_8;
            2'b10:   o_disp_len = modrm_pkg::DISP_16;
            default: o_disp_len = modrm_pkg::DISP_0;
        endcase
    end

endmodule

// File: modrm_ea32_decode.sv
// 32-bit effective address decode
// r/m register as base, sib escape on r/m 4 and disp32 direct form
`timescale 1ns/100ps

module modrm_ea32_decode (
    input  modrm_pkg::mod_t      i_mod,
    input  modrm_pkg::rm_t       i_rm,
    output modrm_pkg::sreg_idx_t o_seg,
    output logic                 o_base_present,
    output modrm_pkg::gpr_idx_t  o_base,
    output logic                 o_index_present,
    output modrm_pkg::gpr_idx_t  o_index,
    output logic                 o_sib_present,
    output modrm_pkg::disp_len_t o_disp_len
);

    // mod 0 with r/m 5 is a bare disp32
    logic direct32;

    assign direct32 = (i_mod == 2'b00) && (i_rm == modrm_pkg::RM32_DIRECT);

    // r/m 4 hands base/index over to the sib byte
    assign o_sib_present = (i_rm == modrm_pkg::RM_SIB);

    // base is the r/m register unless sib or direct
    assign o_base_present = ~o_sib_present & ~direct32;
    assign o_base         = o_base_present ? modrm_pkg::gpr_idx_t'(i_rm) : '0;

    // without sib there is never an index in 32-bit mode
    assign o_index_present = 1'b0;
    assign o_index         = '0;

    // ebp base selects ss, sib and direct forms stay on ds
    assign o_seg = (o_base_present && (o_base == modrm_pkg::GPR_EBP)) ?
                   modrm_pkg::SREG_SS : modrm_pkg::SREG_DS;

    // mod 2 carries a full disp32 in this mode
    always_comb begin
        case (i_mod)
            2'b00:   o_disp_len = direct32 ? modrm_pkg::DISP_32 : modrm_pkg::DISP_0;
            2'b01:   o_disp_len = modrm_pkg::DISP_8;
            2'b10:   o_disp_len = modrm_pkg::DISP_32;
            default: o_disp_len = modrm_pkg::DISP_0;
        endcase
    end

endmodule

// File: modrm_reg_operand.sv
// register-direct operand decode
// detects mod 3 and picks the register index and operand width
`timescale 1ns/100ps

module modrm_reg_operand (
    input  modrm_pkg::mod_t       i_mod,
    input  modrm_pkg::rm_t        i_rm,
    input  logic                  i_w_present,
    input  logic                  i_w,
    input  logic                  i_size32,
    output logic                  o_reg_present,
    output modrm_pkg::gpr_idx_t   o_reg_index,
    output modrm_pkg::op_width_t  o_reg_width
);

    // only place where mod 3 is tested
    assign o_reg_present = (i_mod == modrm_pkg::MOD_REG);

    // r/m names the register directly
    assign o_reg_index = modrm_pkg::gpr_idx_t'(i_rm);

    // w=0 forces a byte register, otherwise default size decides
    // no w bit in the opcode means full width
    always_comb begin
        if (i_w_present && !i_w) begin
            o_reg_width = modrm_pkg::W_8;
        end else if (i_size32) begin
            o_reg_width = modrm_pkg::W_32;
        end else begin
            o_reg_width = modrm_pkg::W_16;
        end
    end

endmodule

// File: modrm_capture.sv
// handshake capture stage
// four-phase req/ack fsm, 16/32-bit result select and output registers
`timescale 1ns/100ps

module modrm_capture (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_req,
    output logic                  o_ack,
    input  logic                  i_size32,
    // 16-bit address decode
    input  modrm_pkg::sreg_idx_t  i_e16_seg,
    input  logic                  i_e16_base_present,
    input  modrm_pkg::gpr_idx_t   i_e16_base,
    input  logic                  i_e16_index_present,
    input  modrm_pkg::gpr_idx_t   i_e16_index,
    input  modrm_pkg::disp_len_t  i_e16_disp_len,
    // 32-bit address decode
    input  modrm_pkg::sreg_idx_t  i_e32_seg,
    input  logic                  i_e32_base_present,
    input  modrm_pkg::gpr_idx_t   i_e32_base,
    input  logic                  i_e32_index_present,
    input  modrm_pkg::gpr_idx_t   i_e32_index,
    input  logic                  i_e32_sib_present,
    input  modrm_pkg::disp_len_t  i_e32_disp_len,
    // register operand decode
    input  logic                  i_reg_present,
    input  modrm_pkg::gpr_idx_t   i_reg_index,
    input  modrm_pkg::op_width_t  i_reg_width,
    // held results
    output modrm_pkg::sreg_idx_t  o_seg,
    output logic                  o_base_present,
    output modrm_pkg::gpr_idx_t   o_base,
    output logic                  o_index_present,
    output modrm_pkg::gpr_idx_t   o_index,
    output logic                  o_sib_present,
    output modrm_pkg::disp_len_t  o_disp_len,
    output logic                  o_reg_present,
    output modrm_pkg::gpr_idx_t   o_reg_index,
    output modrm_pkg::op_width_t  o_reg_width
);

    modrm_pkg::capture_state_t state;

    // selected and masked result, loaded on capture
    modrm_pkg::sreg_idx_t  nxt_seg;
    logic                  nxt_base_present;
    modrm_pkg::gpr_idx_t   nxt_base;
    logic                  nxt_index_present;
    modrm_pkg::gpr_idx_t   nxt_index;
    logic                  nxt_sib_present;
    modrm_pkg::disp_len_t  nxt_disp_len;
    modrm_pkg::gpr_idx_t   nxt_reg_index;

    logic capture;

    // new request seen while idle
    assign capture = (state == modrm_pkg::ST_IDLE) && i_req;

    assign o_ack = (state == modrm_pkg::ST_ACK);

    // 16/32 select before register-direct clears the memory side
    always_comb begin
        if (i_size32) begin
            nxt_seg           = i_e32_seg;
            nxt_base_present  = i_e32_base_present;
            nxt_base          = i_e32_base;
            nxt_index_present = i_e32_index_present;
            nxt_index         = i_e32_index;
            nxt_sib_present   = i_e32_sib_present;
            nxt_disp_len      = i_e32_disp_len;
        end else begin
            nxt_seg           = i_e16_seg;
            nxt_base_present  = i_e16_base_present;
            nxt_base          = i_e16_base;
            nxt_index_present = i_e16_index_present;
            nxt_index         = i_e16_index;
            // no sib byte in 16-bit addressing
            nxt_sib_present   = 1'b0;
            nxt_disp_len      = i_e16_disp_len;
        end
        // memory forms report register index 0
        nxt_reg_index = i_reg_present ? i_reg_index : '0;
        if (i_reg_present) begin
            nxt_seg           = '0;
            nxt_base_present  = 1'b0;
            nxt_base          = '0;
            nxt_index_present = 1'b0;
            nxt_index         = '0;
            nxt_sib_present   = 1'b0;
            nxt_disp_len      = modrm_pkg::DISP_0;
        end
    end

    // idle to ack on req high and back to idle on req low
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= modrm_pkg::ST_IDLE;
        end else begin
            case (state)
                modrm_pkg::ST_IDLE: begin
                    if (i_req) begin
                        state <= modrm_pkg::ST_ACK;
                    end
                end
                default: begin
                    if (!i_req) begin
                        state <= modrm_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    // outputs hold between captures
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_seg           <= '0;
            o_base_present  <= 1'b0;
            o_base          <= '0;
            o_index_present <= 1'b0;
            o_index         <= '0;
            o_sib_present   <= 1'b0;
            o_disp_len      <= modrm_pkg::DISP_0;
            o_reg_present   <= 1'b0;
            o_reg_index     <= '0;
            o_reg_width     <= modrm_pkg::W_NONE;
        end else if (capture) begin
            o_seg           <= nxt_seg;
            o_base_present  <= nxt_base_present;
            o_base          <= nxt_base;
            o_index_present <= nxt_index_present;
            o_index         <= nxt_index;
            o_sib_present   <= nxt_sib_present;
            o_disp_len      <= nxt_disp_len;
            o_reg_present   <= i_reg_present;
            o_reg_index     <= nxt_reg_index;
            // width is reported for memory forms too
            o_reg_width     <= i_reg_width;
        end
    end

endmodule

// File: modrm_decode_top.sv
// mod r/m decode top level
// three combinational decoders feeding one handshake capture stage
`timescale 1ns/100ps

module modrm_decode_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_req,
    output logic                  o_ack,
    input  modrm_pkg::mod_t       i_mod,
    input  modrm_pkg::rm_t        i_rm,
    input  logic                  i_w_present,
    input  logic                  i_w,
    input  logic                  i_size32,
    output modrm_pkg::sreg_idx_t  o_seg,
    output logic                  o_base_present,
    output modrm_pkg::gpr_idx_t   o_base,
    output logic                  o_index_present,
    output modrm_pkg::gpr_idx_t   o_index,
    output logic                  o_sib_present,
    output modrm_pkg::disp_len_t  o_disp_len,
    output logic                  o_reg_present,
    output modrm_pkg::gpr_idx_t   o_reg_index,
    output modrm_pkg::op_width_t  o_reg_width
);

    // 16-bit decode results
    modrm_pkg::sreg_idx_t  e16_seg;
    logic                  e16_base_present;
    modrm_pkg::gpr_idx_t   e16_base;
    logic                  e16_index_present;
    modrm_pkg::gpr_idx_t   e16_index;
    modrm_pkg::disp_len_t  e16_disp_len;

    // 32-bit decode results
    modrm_pkg::sreg_idx_t  e32_seg;
    logic                  e32_base_present;
    modrm_pkg::gpr_idx_t   e32_base;
    logic                  e32_index_present;
    modrm_pkg::gpr_idx_t   e32_index;
    logic                  e32_sib_present;
    modrm_pkg::disp_len_t  e32_disp_len;

    // register operand
    logic                  reg_present;
    modrm_pkg::gpr_idx_t   reg_index;
    modrm_pkg::op_width_t  reg_width;

    modrm_ea16_decode modrm_ea16_decode_inst (
        .i_mod           (i_mod),
        .i_rm            (i_rm),
        .o_seg           (e16_seg),
        .o_base_present  (e16_base_present),
        .o_base          (e16_base),
        .o_index_present (e16_index_present),
        .o_index         (e16_index),
        .o_disp_len      (e16_disp_len)
    );

    modrm_ea32_decode modrm_ea32_decode_inst (
        .i_mod           (i_mod),
        .i_rm            (i_rm),
        .o_seg           (e32_seg),
        .o_base_present  (e32_base_present),
        .o_base          (e32_base),
        .o_index_present (e32_index_present),
        .o_index         (e32_index),
        .o_sib_present   (e32_sib_present),
        .o_disp_len      (e32_disp_len)
    );

    modrm_reg_operand modrm_reg_operand_inst (
        .i_mod         (i_mod),
        .i_rm          (i_rm),
        .i_w_present   (i_w_present),
        .i_w           (i_w),
        .i_size32      (i_size32),
        .o_reg_present (reg_present),
        .o_reg_index   (reg_index),
        .o_reg_width   (reg_width)
    );

    modrm_capture modrm_capture_inst (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_req               (i_req),
        .o_ack               (o_ack),
        .i_size32            (i_size32),
        .i_e16_seg           (e16_seg),
        .i_e16_base_present  (e16_base_present),
        .i_e16_base          (e16_base),
        .i_e16_index_present (e16_index_present),
        .i_e16_index         (e16_index),
        .i_e16_disp_len      (e16_disp_len),
        .i_e32_seg           (e32_seg),
        .i_e32_base_present  (e32_base_present),
        .i_e32_base          (e32_base),
        .i_e32_index_present (e32_index_present),
        .i_e32_index         (e32_index),
        .i_e32_sib_present   (e32_sib_present),
        .i_e32_disp_len      (e32_disp_len),
        .i_reg_present       (reg_present),
        .i_reg_index         (reg_index),
        .i_reg_width         (reg_width),
        .o_seg               (o_seg),
        .o_base_present      (o_base_present),
        .o_base              (o_base),
        .o_index_present     (o_index_present),
        .o_index             (o_index),
        .o_sib_present       (o_sib_present),
        .o_disp_len          (o_disp_len),
        .o_reg_present       (o_reg_present),
        .o_reg_index         (o_reg_index),
        .o_reg_width         (o_reg_width)
    );

endmodule

// File: modrm_decode_tb.sv
// mod r/m decode testbench
// replays the stim file through the req/ack handshake and checks every field
`timescale 1ns/100ps

module modrm_decode_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 10;
    // drive, ack, drop and minimum gap
    localparam int HS_CYCLES  = 4;
    // worst case hold time plus extra gap
    localparam int MAX_GAP    = 7;
    localparam int ACK_LIMIT  = 8;
    localparam int WD_MARGIN  = 50;
    localparam string STIM_FILE = "modrm_stim.txt";

    // one stim line without its name
    typedef struct packed {
        logic       size32;
        logic [1:0] mod;
        logic [2:0] rm;
        logic       w_present;
        logic       w;
        logic [2:0] seg;
        logic       base_present;
        logic [2:0] base;
        logic       index_present;
        logic [2:0] index;
        logic       sib;
        logic [2:0] disp;
        logic       reg_present;
        logic [2:0] reg_index;
        logic [5:0] width_bits;
    } vector_t;

    logic clk;
    logic rst_n;
    logic req;
    logic ack;
    modrm_pkg::mod_t      mod;
    modrm_pkg::rm_t       rm;
    logic                 w_present;
    logic                 w;
    logic                 size32;
    modrm_pkg::sreg_idx_t seg;
    logic                 base_present;
    modrm_pkg::gpr_idx_t  base;
    logic                 index_present;
    modrm_pkg::gpr_idx_t  index;
    logic                 sib_present;
    modrm_pkg::disp_len_t disp_len;
    logic                 reg_present;
    modrm_pkg::gpr_idx_t  reg_index;
    modrm_pkg::op_width_t reg_width;

    int      value_errors;
    int      other_errors;
    integer  seed;
    bit      loaded;
    string   names[$];
    vector_t vecs[$];

    modrm_decode_top modrm_decode_top_inst (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_req           (req),
        .o_ack           (ack),
        .i_mod           (mod),
        .i_rm            (rm),
        .i_w_present     (w_present),
        .i_w             (w),
        .i_size32        (size32),
        .o_seg           (seg),
        .o_base_present  (base_present),
        .o_base          (base),
        .o_index_present (index_present),
        .o_index         (index),
        .o_sib_present   (sib_present),
        .o_disp_len      (disp_len),
        .o_reg_present   (reg_present),
        .o_reg_index     (reg_index),
        .o_reg_width     (reg_width)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // stim file gives width in bits
    function automatic modrm_pkg::op_width_t width_code(input int bits);
        case (bits)
            8:       return modrm_pkg::W_8;
            16:      return modrm_pkg::W_16;
            32:      return modrm_pkg::W_32;
            default: return modrm_pkg::W_NONE;
        endcase
    endfunction

    task automatic check_value(input string test, input string field,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("error %s %s expected %0d actual %0d", test, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_outputs(input string test, input vector_t v);
        check_value(test, "seg", v.seg, seg);
        check_value(test, "base_present", v.base_present, base_present);
        check_value(test, "base", v.base, base);
        check_value(test, "index_present", v.index_present, index_present);
        check_value(test, "index", v.index, index);
        check_value(test, "sib_present", v.sib, sib_present);
        check_value(test, "disp_len", v.disp, disp_len);
        check_value(test, "reg_present", v.reg_present, reg_present);
        check_value(test, "reg_index", v.reg_index, reg_index);
        check_value(test, "reg_width", int'(width_code(v.width_bits)), int'(reg_width));
    endtask

    task automatic load_stim;
        int      fd;
        int      cnt;
        int      f[15];
        string   line;
        string   name;
        vector_t v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // lines starting with # are comments
            if (line.len() > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                              f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                if (cnt == 16) begin
                    v = '{f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                          f[8], f[9], f[10], f[11], f[12], f[13], f[14]};
                    names.push_back(name);
                    vecs.push_back(v);
                end else if (cnt > 0) begin
                    $display("malformed stimulus line: %s", line);
                    other_errors++;
                end
            end
        end
        $fclose(fd);
        if (names.size() == 0) begin
            $display("no test vectors found in %s", STIM_FILE);
            other_errors++;
        end
    endtask

    task automatic reset_dut;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ack is high during reset");
            other_errors++;
        end
        rst_n = 1'b1;
    endtask

    // counts falling edges until ack reaches level or the limit runs out
    task automatic wait_for_ack(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((ack !== level) && (cycles < ACK_LIMIT));
    endtask

    // requester is free to change operands once ack is seen
    task automatic scramble_inputs;
        integer r;
        r         = $random(seed);
        mod       = r[1:0];
        rm        = r[4:2];
        w_present = r[5];
        w         = r[6];
        size32    = r[7];
    endtask

    task automatic run_vector(input string test, input vector_t v);
        int cycles;
        int hold;
        int gap;
        @(negedge clk);
        size32    = v.size32;
        mod       = v.mod;
        rm        = v.rm;
        w_present = v.w_present;
        w         = v.w;
        req       = 1'b1;
        wait_for_ack(1'b1, cycles);
        if (ack !== 1'b1) begin
            $display("%s: ack did not rise within %0d cycles of req", test, ACK_LIMIT);
            other_errors++;
        end else if (cycles != 1) begin
            $display("%s: ack rose %0d cycles after req instead of 1", test, cycles);
            other_errors++;
        end
        check_outputs(test, v);
        // keep req high a while with new operands, outputs must not move
        hold = $unsigned($random(seed)) % 4;
        scramble_inputs();
        repeat (hold) @(negedge clk);
        if (ack !== 1'b1) begin
            $display("%s: ack dropped while req was still high", test);
            other_errors++;
        end
        check_outputs(test, v);
        req = 1'b0;
        wait_for_ack(1'b0, cycles);
        if (ack !== 1'b0) begin
            $display("%s: ack did not fall within %0d cycles of req low", test, ACK_LIMIT);
            other_errors++;
        end else if (cycles != 1) begin
            $display("%s: ack fell %0d cycles after req low instead of 1", test, cycles);
            other_errors++;
        end
        check_outputs(test, v);
        gap = 1 + $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        // held until the next capture
        check_outputs(test, v);
    endtask

    initial begin
        req          = 1'b0;
        mod          = '0;
        rm           = '0;
        w_present    = 1'b0;
        w            = 1'b0;
        size32       = 1'b0;
        rst_n        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        seed         = 47;
        loaded       = 1'b0;
        load_stim();
        loaded = 1'b1;
        reset_dut();
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ack is high right after reset");
            other_errors++;
        end
        check_outputs("reset", '0);
        foreach (vecs[i]) begin
            run_vector(names[i], vecs[i]);
        end
        @(negedge clk);
        $display("%0d vectors, %0d value errors, %0d handshake or other errors",
                 vecs.size(), value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // bound the run by the vector count
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(vecs.size()) * (HS_CYCLES + MAX_GAP) * CLK_PERIOD
                 + (RST_CYCLES + WD_MARGIN) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired after %0d ns, handshakes did not complete", limit_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: modrm_stim.txt
# name size32 mod rm w_present w  seg base_present base index_present index sib disp_len
#   reg_present reg_index width_bits   (registers BX=3 BP=5 SI=6 DI=7, segments SS=2 DS=3)
a16_m0_r0 0 0 0 1 1  3 1 3 1 6 0 0  0 0 16
a16_m0_r1 0 0 1 1 1  3 1 3 1 7 0 0  0 0 16
a16_m0_r2 0 0 2 1 1  2 1 5 1 6 0 0  0 0 16
a16_m0_r3 0 0 3 1 1  2 1 5 1 7 0 0  0 0 16
a16_m0_r4 0 0 4 1 1  3 0 0 1 6 0 0  0 0 16
a16_m0_r5 0 0 5 1 1  3 0 0 1 7 0 0  0 0 16
a16_m0_r6 0 0 6 1 1  3 0 0 0 0 0 2  0 0 16
a16_m0_r7 0 0 7 1 1  3 1 3 0 0 0 0  0 0 16
a16_m1_r0 0 1 0 0 0  3 1 3 1 6 0 1  0 0 16
a16_m1_r1 0 1 1 0 0  3 1 3 1 7 0 1  0 0 16
a16_m1_r2 0 1 2 0 0  2 1 5 1 6 0 1  0 0 16
a16_m1_r3 0 1 3 0 0  2 1 5 1 7 0 1  0 0 16
a16_m1_r4 0 1 4 0 0  3 0 0 1 6 0 1  0 0 16
a16_m1_r5 0 1 5 0 0  3 0 0 1 7 0 1  0 0 16
a16_m1_r6 0 1 6 0 0  2 1 5 0 0 0 1  0 0 16
a16_m1_r7 0 1 7 0 0  3 1 3 0 0 0 1  0 0 16
a16_m2_r0 0 2 0 1 0  3 1 3 1 6 0 2  0 0 8
a16_m2_r1 0 2 1 1 0  3 1 3 1 7 0 2  0 0 8
a16_m2_r2 0 2 2 1 0  2 1 5 1 6 0 2  0 0 8
a16_m2_r3 0 2 3 1 0  2 1 5 1 7 0 2  0 0 8
a16_m2_r4 0 2 4 1 0  3 0 0 1 6 0 2  0 0 8
a16_m2_r5 0 2 5 1 0  3 0 0 1 7 0 2  0 0 8
a16_m2_r6 0 2 6 1 0  2 1 5 0 0 0 2  0 0 8
a16_m2_r7 0 2 7 1 0  3 1 3 0 0 0 2  0 0 8
a16_m3_r0 0 3 0 1 0  0 0 0 0 0 0 0  1 0 8
a16_m3_r1 0 3 1 1 1  0 0 0 0 0 0 0  1 1 16
a16_m3_r2 0 3 2 0 0  0 0 0 0 0 0 0  1 2 16
a16_m3_r3 0 3 3 0 1  0 0 0 0 0 0 0  1 3 16
a16_m3_r4 0 3 4 1 0  0 0 0 0 0 0 0  1 4 8
a16_m3_r5 0 3 5 1 1  0 0 0 0 0 0 0  1 5 16
a16_m3_r6 0 3 6 0 0  0 0 0 0 0 0 0  1 6 16
a16_m3_r7 0 3 7 1 0  0 0 0 0 0 0 0  1 7 8
a32_m0_r0 1 0 0 1 1  3 1 0 0 0 0 0  0 0 32
a32_m0_r1 1 0 1 1 1  3 1 1 0 0 0 0  0 0 32
a32_m0_r2 1 0 2 1 1  3 1 2 0 0 0 0  0 0 32
a32_m0_r3 1 0 3 1 1  3 1 3 0 0 0 0  0 0 32
a32_m0_r4 1 0 4 1 1  3 0 0 0 0 1 0  0 0 32
a32_m0_r5 1 0 5 1 1  3 0 0 0 0 0 4  0 0 32
a32_m0_r6 1 0 6 1 1  3 1 6 0 0 0 0  0 0 32
a32_m0_r7 1 0 7 1 1  3 1 7 0 0 0 0  0 0 32
a32_m1_r0 1 1 0 0 0  3 1 0 0 0 0 1  0 0 32
a32_m1_r1 1 1 1 0 0  3 1 1 0 0 0 1  0 0 32
a32_m1_r2 1 1 2 0 0  3 1 2 0 0 0 1  0 0 32
a32_m1_r3 1 1 3 0 0  3 1 3 0 0 0 1  0 0 32
a32_m1_r4 1 1 4 0 0  3 0 0 0 0 1 1  0 0 32
a32_m1_r5 1 1 5 0 0  2 1 5 0 0 0 1  0 0 32
a32_m1_r6 1 1 6 0 0  3 1 6 0 0 0 1  0 0 32
a32_m1_r7 1 1 7 0 0  3 1 7 0 0 0 1  0 0 32
a32_m2_r0 1 2 0 1 0  3 1 0 0 0 0 4  0 0 8
a32_m2_r1 1 2 1 1 0  3 1 1 0 0 0 4  0 0 8
a32_m2_r2 1 2 2 1 0  3 1 2 0 0 0 4  0 0 8
a32_m2_r3 1 2 3 1 0  3 1 3 0 0 0 4  0 0 8
a32_m2_r4 1 2 4 1 0  3 0 0 0 0 1 4  0 0 8
a32_m2_r5 1 2 5 1 0  2 1 5 0 0 0 4  0 0 8
a32_m2_r6 1 2 6 1 0  3 1 6 0 0 0 4  0 0 8
a32_m2_r7 1 2 7 1 0  3 1 7 0 0 0 4  0 0 8
a32_m3_r0 1 3 0 1 0  0 0 0 0 0 0 0  1 0 8
a32_m3_r1 1 3 1 1 1  0 0 0 0 0 0 0  1 1 32
a32_m3_r2 1 3 2 0 0  0 0 0 0 0 0 0  1 2 32
a32_m3_r3 1 3 3 0 1  0 0 0 0 0 0 0  1 3 32
a32_m3_r4 1 3 4 1 0  0 0 0 0 0 0 0  1 4 8
a32_m3_r5 1 3 5 1 1  0 0 0 0 0 0 0  1 5 32
a32_m3_r6 1 3 6 0 0  0 0 0 0 0 0 0  1 6 32
a32_m3_r7 1 3 7 1 0  0 0 0 0 0 0 0  1 7 8

// File: all.f
modrm_pkg.sv
modrm_ea16_decode.sv
modrm_ea32_decode.sv
modrm_reg_operand.sv
modrm_capture.sv
modrm_decode_top.sv
modrm_decode_tb.sv

// File: Bender.yml
package:
  name: modrm_decode

sources:
  - files:
      - modrm_pkg.sv
      - modrm_ea16_decode.sv
      - modrm_ea32_decode.sv
      - modrm_reg_operand.sv
      - modrm_capture.sv
      - modrm_decode_top.sv
  - target: simulation
    files:
      - modrm_decode_tb.sv
